/* include/ooo_defines.svh */
// width and depth constants of the out-of-order integer core
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath width
`define OOO_XLEN 32

// architectural register count
`define OOO_NUM_REGS 32

// reorder buffer, depth must stay a power of two
`define OOO_ROB_DEPTH 8
`define OOO_ROB_TAG_W 3

// default alu reservation station depth
`define OOO_RS_DEPTH 4

`endif

/* design/ooo_isa_pkg.sv */
// RV32 instruction encoding and ALU operation types used by the core
package ooo_isa_pkg;

	// raw instruction word
	typedef logic [31:0] inst_t;

	// supported major opcodes
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011
	} opcode_t;

	// field view of an R-type word, I-type shares opcode, rd, funct3 and rs1
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} r_inst_t;

	// funct3 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 codes, alt selects SUB
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_NOP
	} alu_op_t;

endpackage

/* design/ooo_core_pkg.sv */
// microarchitectural widths and packet structs shared by the core blocks
`include "ooo_defines.svh"

package ooo_core_pkg;

	// widths with a meaning
	typedef logic [`OOO_XLEN-1:0]      data_t;
	typedef logic [4:0]                reg_idx_t;
	typedef logic [`OOO_ROB_TAG_W-1:0] rob_tag_t;

	// rename entry, ready means the value already sits in the rob
	typedef struct packed {
		logic     busy;
		rob_tag_t tag;
		logic     ready;
	} map_entry_t;

	// source operand, tag only meaningful while not ready
	typedef struct packed {
		logic     ready;
		data_t    value;
		rob_tag_t tag;
	} operand_t;

	// one dispatched instruction
	typedef struct packed {
		logic                valid;
		ooo_isa_pkg::inst_t  inst;
		reg_idx_t            dest;
		ooo_isa_pkg::alu_op_t alu_op;
		operand_t            a;
		operand_t            b;
		rob_tag_t            tag;
	} dispatch_packet_t;

	// single common data bus
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		data_t    value;
	} cdb_t;

	// one retired instruction
	typedef struct packed {
		logic               valid;
		ooo_isa_pkg::inst_t inst;
		logic               wr_en;
		reg_idx_t           wr_idx;
		data_t              wr_data;
	} commit_packet_t;

endpackage

/* design/issue_stage.sv */
// issue stage with decode, register file, operand sourcing and dispatch stall
`timescale 1ns/1ps
`include "ooo_defines.svh"

module issue_stage (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             inst_valid,
	input  ooo_isa_pkg::inst_t               inst,
	input  logic                             rob_full,
	input  logic                             rs_full,
	input  ooo_core_pkg::map_entry_t         map_rs1,
	input  ooo_core_pkg::map_entry_t         map_rs2,
	input  ooo_core_pkg::data_t              rob_value_rs1,
	input  ooo_core_pkg::data_t              rob_value_rs2,
	input  ooo_core_pkg::rob_tag_t           alloc_tag,
	input  ooo_core_pkg::commit_packet_t     commit,
	output ooo_core_pkg::reg_idx_t           rs1_idx,
	output ooo_core_pkg::reg_idx_t           rs2_idx,
	output ooo_core_pkg::dispatch_packet_t   dispatch,
	output logic                             dispatch_en,
	output logic                             stall
);

	ooo_core_pkg::data_t  regfile [`OOO_NUM_REGS];
	ooo_isa_pkg::r_inst_t fields;
	ooo_isa_pkg::alu_op_t alu_op;
	ooo_core_pkg::data_t  imm;
	logic                 is_imm;

	// pick regfile, finished rob value or pending tag
	function automatic ooo_core_pkg::operand_t select_operand(
		input ooo_core_pkg::reg_idx_t   idx,
		input ooo_core_pkg::map_entry_t map_entry,
		input ooo_core_pkg::data_t      rf_value,
		input ooo_core_pkg::data_t      rob_value
	);
		ooo_core_pkg::operand_t op;
		op.ready = 1'b1;
		op.value = '0;
		op.tag   = map_entry.tag;
		if (idx == '0) begin
			op.value = '0;
		end else if (!map_entry.busy) begin
			op.value = rf_value;
		end else if (map_entry.ready) begin
			op.value = rob_value;
		end else begin
			// still in flight, wait on the bus
			op.ready = 1'b0;
		end
		return op;
	endfunction

	//////////////////////////////
	// decode
	//////////////////////////////
	assign fields  = ooo_isa_pkg::r_inst_t'(inst);
	assign rs1_idx = fields.rs1;
	assign rs2_idx = fields.rs2;
	// I-type immediate, sign extended
	assign imm = {{(`OOO_XLEN-12){inst[31]}}, inst[31:20]};

	always_comb begin
		alu_op = ooo_isa_pkg::ALU_NOP;
		is_imm = 1'b0;
		case (fields.opcode)
			ooo_isa_pkg::OP: begin
				if (fields.funct7 == ooo_isa_pkg::F7_BASE) begin
					case (fields.funct3)
						ooo_isa_pkg::F3_ADD_SUB: alu_op = ooo_isa_pkg::ALU_ADD;
						ooo_isa_pkg::F3_SLT:     alu_op = ooo_isa_pkg::ALU_SLT;
						ooo_isa_pkg::F3_XOR:     alu_op = ooo_isa_pkg::ALU_XOR;
						ooo_isa_pkg::F3_OR:      alu_op = ooo_isa_pkg::ALU_OR;
						ooo_isa_pkg::F3_AND:     alu_op = ooo_isa_pkg::ALU_AND;
						default:                 alu_op = ooo_isa_pkg::ALU_NOP;
					endcase
				end else if (fields.funct7 == ooo_isa_pkg::F7_ALT &&
						fields.funct3 == ooo_isa_pkg::F3_ADD_SUB) begin
					alu_op = ooo_isa_pkg::ALU_SUB;
				end
			end
			ooo_isa_pkg::OP_IMM: begin
				// only ADDI
				if (fields.funct3 == ooo_isa_pkg::F3_ADD_SUB) begin
					alu_op = ooo_isa_pkg::ALU_ADD;
					is_imm = 1'b1;
				end
			end
			default: alu_op = ooo_isa_pkg::ALU_NOP;
		endcase
	end

	//////////////////////////////
	// register file
	//////////////////////////////
	// written at commit, x0 never written
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `OOO_NUM_REGS; i++) begin
				regfile[i] <= '0;
			end
		end else if (commit.valid && commit.wr_en && commit.wr_idx != '0) begin
			regfile[commit.wr_idx] <= commit.wr_data;
		end
	end

	//////////////////////////////
	// dispatch
	//////////////////////////////
	// hold input while either structure is out of room
	assign stall       = rob_full || rs_full;
	assign dispatch_en = inst_valid && !stall;

	always_comb begin
		dispatch.valid  = dispatch_en;
		dispatch.inst   = inst;
		// unsupported words retire with no register write
		dispatch.dest   = (alu_op == ooo_isa_pkg::ALU_NOP) ? '0 : fields.rd;
		dispatch.alu_op = alu_op;
		dispatch.a      = select_operand(rs1_idx, map_rs1, regfile[rs1_idx], rob_value_rs1);
		dispatch.b      = select_operand(rs2_idx, map_rs2, regfile[rs2_idx], rob_value_rs2);
		if (is_imm) begin
			dispatch.b.ready = 1'b1;
			dispatch.b.value = imm;
		end
		dispatch.tag    = alloc_tag;
	end

endmodule

/* design/map_table.sv */
// rename map from architectural register to newest reorder buffer producer
`timescale 1ns/1ps
`include "ooo_defines.svh"

module map_table (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           dispatch_en,
	input  ooo_core_pkg::dispatch_packet_t dispatch,
	input  ooo_core_pkg::cdb_t             cdb,
	input  ooo_core_pkg::commit_packet_t   commit,
	input  ooo_core_pkg::rob_tag_t         commit_tag,
	input  ooo_core_pkg::reg_idx_t         rs1_idx,
	input  ooo_core_pkg::reg_idx_t         rs2_idx,
	output ooo_core_pkg::map_entry_t       map_rs1,
	output ooo_core_pkg::map_entry_t       map_rs2
);

	ooo_core_pkg::map_entry_t map_q [`OOO_NUM_REGS];

	assign map_rs1 = map_q[rs1_idx];
	assign map_rs2 = map_q[rs2_idx];

	// later statements win, so dispatch beats commit clear
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `OOO_NUM_REGS; r++) begin
				map_q[r] <= '0;
			end
		end else begin
			// bus result now captured by the rob
			for (int r = 0; r < `OOO_NUM_REGS; r++) begin
				if (cdb.valid && map_q[r].busy && map_q[r].tag == cdb.tag) begin
					map_q[r].ready <= 1'b1;
				end
			end
			// value moves to the regfile, unless renamed again meanwhile
			if (commit.valid && commit.wr_en && map_q[commit.wr_idx].tag == commit_tag) begin
				map_q[commit.wr_idx].busy <= 1'b0;
			end
			if (dispatch_en && dispatch.dest != '0) begin
				map_q[dispatch.dest].busy  <= 1'b1;
				map_q[dispatch.dest].tag   <= dispatch.tag;
				map_q[dispatch.dest].ready <= 1'b0;
			end
		end
	end

endmodule

/* design/reorder_buffer.sv */
// circular reorder buffer with allocation, result capture and in-order commit
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reorder_buffer (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           dispatch_en,
	input  ooo_core_pkg::dispatch_packet_t dispatch,
	input  ooo_core_pkg::cdb_t             cdb,
	input  ooo_core_pkg::rob_tag_t         read_tag_rs1,
	input  ooo_core_pkg::rob_tag_t         read_tag_rs2,
	output ooo_core_pkg::data_t            rob_value_rs1,
	output ooo_core_pkg::data_t            rob_value_rs2,
	output ooo_core_pkg::rob_tag_t         alloc_tag,
	output logic                           full,
	output ooo_core_pkg::commit_packet_t   commit,
	output ooo_core_pkg::rob_tag_t         commit_tag
);

	localparam int CNT_W = `OOO_ROB_TAG_W + 1;

	// entry storage
	ooo_isa_pkg::inst_t     entry_inst  [`OOO_ROB_DEPTH];
	ooo_core_pkg::reg_idx_t entry_dest  [`OOO_ROB_DEPTH];
	ooo_core_pkg::data_t    entry_value [`OOO_ROB_DEPTH];
	logic [`OOO_ROB_DEPTH-1:0] entry_done;

	ooo_core_pkg::rob_tag_t head;
	ooo_core_pkg::rob_tag_t tail;
	logic [CNT_W-1:0]       count;
	logic                   head_ready;

	assign alloc_tag  = tail;
	assign full       = (count == CNT_W'(`OOO_ROB_DEPTH));
	assign head_ready = (count != '0) && entry_done[head];

	// operand read for finished producers
	assign rob_value_rs1 = entry_value[read_tag_rs1];
	assign rob_value_rs2 = entry_value[read_tag_rs2];

	//////////////////////////////
	// pointers
	//////////////////////////////
	// tags wrap on their own, depth is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (dispatch_en) begin
				tail <= tail + 1'b1;
			end
			if (head_ready) begin
				head <= head + 1'b1;
			end
			count <= count + CNT_W'(dispatch_en) - CNT_W'(head_ready);
		end
	end

	//////////////////////////////
	// entries
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (dispatch_en) begin
			entry_inst[tail] <= dispatch.inst;
			entry_dest[tail] <= dispatch.dest;
			// nop has nothing to wait for
			entry_done[tail] <= (dispatch.alu_op == ooo_isa_pkg::ALU_NOP);
		end
		// bus capture
		if (cdb.valid) begin
			entry_value[cdb.tag] <= cdb.value;
			entry_done[cdb.tag]  <= 1'b1;
		end
	end

	//////////////////////////////
	// commit
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
			commit.wr_en <= 1'b0;
		end else begin
			commit.valid <= head_ready;
			commit.wr_en <= head_ready && entry_dest[head] != '0;
		end
		commit.inst    <= entry_inst[head];
		commit.wr_idx  <= entry_dest[head];
		commit.wr_data <= entry_value[head];
		commit_tag     <= head;
	end

endmodule

/* design/reservation_station.sv */
// alu reservation station with bus wakeup and oldest-ready select
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station #(
	parameter int depth = `OOO_RS_DEPTH
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           dispatch_en,
	input  ooo_core_pkg::dispatch_packet_t dispatch,
	input  ooo_core_pkg::cdb_t             cdb,
	output logic                           full,
	output ooo_core_pkg::dispatch_packet_t issue_out
);

	localparam int SEL_W = (depth > 1) ? $clog2(depth) : 1;

	// entries kept compacted, index 0 is the oldest
	ooo_core_pkg::dispatch_packet_t entry_q [depth];
	ooo_core_pkg::dispatch_packet_t entry_d [depth];
	ooo_core_pkg::dispatch_packet_t woken   [depth];
	logic [depth-1:0] ready;
	logic             found;
	logic [SEL_W-1:0] sel;

	// capture a bus value for a waiting operand
	function automatic ooo_core_pkg::operand_t wake(
		input ooo_core_pkg::operand_t op,
		input ooo_core_pkg::cdb_t     bus
	);
		ooo_core_pkg::operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	always_comb begin
		full = 1'b1;
		for (int i = 0; i < depth; i++) begin
			woken[i]   = entry_q[i];
			woken[i].a = wake(entry_q[i].a, cdb);
			woken[i].b = wake(entry_q[i].b, cdb);
			ready[i]   = entry_q[i].valid && entry_q[i].a.ready && entry_q[i].b.ready;
			full       = full && entry_q[i].valid;
		end
	end

	//////////////////////////////
	// select
	//////////////////////////////
	// walk down so the lowest ready index wins
	always_comb begin
		found = 1'b0;
		sel   = '0;
		for (int i = depth - 1; i >= 0; i--) begin
			if (ready[i]) begin
				found = 1'b1;
				sel   = SEL_W'(i);
			end
		end
	end

	assign issue_out = found ? entry_q[sel] : '0;

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb begin
		int unsigned slot;
		slot = 0;
		entry_d = '{default: '0};
		// shift survivors down over the issued entry
		for (int i = 0; i < depth; i++) begin
			if (entry_q[i].valid && !(found && sel == SEL_W'(i))) begin
				entry_d[slot] = woken[i];
				slot++;
			end
		end
		// new entry behind the survivors, nops never enter
		if (dispatch_en && dispatch.alu_op != ooo_isa_pkg::ALU_NOP && slot < depth) begin
			entry_d[slot]       = dispatch;
			entry_d[slot].valid = 1'b1;
			entry_d[slot].a     = wake(dispatch.a, cdb);
			entry_d[slot].b     = wake(dispatch.b, cdb);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				entry_q[i].valid <= 1'b0;
			end
		end else begin
			entry_q <= entry_d;
		end
	end

endmodule

/* design/alu_stage.sv */
// integer alu with the result register that drives the common data bus
`timescale 1ns/1ps

module alu_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  ooo_core_pkg::dispatch_packet_t issue_out,
	output ooo_core_pkg::cdb_t             cdb
);

	ooo_core_pkg::data_t result;

	always_comb begin
		case (issue_out.alu_op)
			ooo_isa_pkg::ALU_ADD: result = issue_out.a.value + issue_out.b.value;
			ooo_isa_pkg::ALU_SUB: result = issue_out.a.value - issue_out.b.value;
			ooo_isa_pkg::ALU_AND: result = issue_out.a.value & issue_out.b.value;
			ooo_isa_pkg::ALU_OR:  result = issue_out.a.value | issue_out.b.value;
			ooo_isa_pkg::ALU_XOR: result = issue_out.a.value ^ issue_out.b.value;
			// signed compare
			ooo_isa_pkg::ALU_SLT: begin
				result = ooo_core_pkg::data_t'($signed(issue_out.a.value) <
					$signed(issue_out.b.value));
			end
			default: result = '0;
		endcase
	end

	// one cycle on the bus per issued op
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= issue_out.valid;
		end
		cdb.tag   <= issue_out.tag;
		cdb.value <= result;
	end

endmodule

/* design/ooo_core.sv */
// top level of the out-of-order rv32 core connecting issue, rename, rob, rs and alu
`timescale 1ns/1ps

module ooo_core (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   inst_valid,
	input  ooo_isa_pkg::inst_t     inst,
	output logic                   stall,
	output logic                   commit_valid,
	output ooo_isa_pkg::inst_t     commit_inst,
	output logic                   commit_wr_en,
	output ooo_core_pkg::reg_idx_t commit_wr_idx,
	output ooo_core_pkg::data_t    commit_wr_data
);

	// issue to rename and rob
	ooo_core_pkg::reg_idx_t         rs1_idx;
	ooo_core_pkg::reg_idx_t         rs2_idx;
	ooo_core_pkg::map_entry_t       map_rs1;
	ooo_core_pkg::map_entry_t       map_rs2;
	ooo_core_pkg::data_t            rob_value_rs1;
	ooo_core_pkg::data_t            rob_value_rs2;
	ooo_core_pkg::dispatch_packet_t dispatch;
	logic                           dispatch_en;

	// rob status and retire
	ooo_core_pkg::rob_tag_t         alloc_tag;
	logic                           rob_full;
	ooo_core_pkg::commit_packet_t   commit;
	ooo_core_pkg::rob_tag_t         commit_tag;

	// execute path
	logic                           rs_full;
	ooo_core_pkg::dispatch_packet_t issue_out;
	ooo_core_pkg::cdb_t             cdb;

	assign commit_valid   = commit.valid;
	assign commit_inst    = commit.inst;
	assign commit_wr_en   = commit.wr_en;
	assign commit_wr_idx  = commit.wr_idx;
	assign commit_wr_data = commit.wr_data;

	issue_stage issue_stage_0 (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst),
		.rob_full(rob_full), .rs_full(rs_full),
		.map_rs1(map_rs1), .map_rs2(map_rs2),
		.rob_value_rs1(rob_value_rs1), .rob_value_rs2(rob_value_rs2),
		.alloc_tag(alloc_tag), .commit(commit),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.dispatch(dispatch), .dispatch_en(dispatch_en), .stall(stall)
	);

	map_table map_table_0 (
		.clock(clock), .reset(reset),
		.dispatch_en(dispatch_en), .dispatch(dispatch), .cdb(cdb),
		.commit(commit), .commit_tag(commit_tag),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.map_rs1(map_rs1), .map_rs2(map_rs2)
	);

	// rob operand reads follow the map tags
	reorder_buffer rob_0 (
		.clock(clock), .reset(reset),
		.dispatch_en(dispatch_en), .dispatch(dispatch), .cdb(cdb),
		.read_tag_rs1(map_rs1.tag), .read_tag_rs2(map_rs2.tag),
		.rob_value_rs1(rob_value_rs1), .rob_value_rs2(rob_value_rs2),
		.alloc_tag(alloc_tag), .full(rob_full),
		.commit(commit), .commit_tag(commit_tag)
	);

	reservation_station alu_rs_0 (
		.clock(clock), .reset(reset),
		.dispatch_en(dispatch_en), .dispatch(dispatch), .cdb(cdb),
		.full(rs_full), .issue_out(issue_out)
	);

	alu_stage alu_0 (
		.clock(clock), .reset(reset),
		.issue_out(issue_out), .cdb(cdb)
	);

endmodule

/* testbench/ooo_core_tb.sv */
// testbench for the out-of-order core, random and directed words against an in-order model
`timescale 1ns/1ps

module ooo_core_tb;

	// about 200 words at up to 8 cycles each, plus reset
	localparam int CYCLE_LIMIT = 1800;
	// a full rob of 8 words at up to 8 cycles each
	localparam int DRAIN_LIMIT = 64;

	typedef struct packed {
		logic                   wr_en;
		ooo_core_pkg::reg_idx_t wr_idx;
		ooo_core_pkg::data_t    wr_data;
	} expect_t;

	logic                   clock;
	logic                   reset;
	logic                   inst_valid;
	ooo_isa_pkg::inst_t     inst;
	logic                   stall;
	logic                   commit_valid;
	ooo_isa_pkg::inst_t     commit_inst;
	logic                   commit_wr_en;
	ooo_core_pkg::reg_idx_t commit_wr_idx;
	ooo_core_pkg::data_t    commit_wr_data;

	// accepted words in program order, with the test each came from
	ooo_isa_pkg::inst_t word_q [$];
	string              name_q [$];

	// architectural state of the in-order model
	ooo_core_pkg::data_t ref_regs [32];
	logic [31:0]         lfsr_state;

	int cycles;
	int accepted_count;
	int commit_count;
	int checks;
	int value_errors;
	int other_errors;
	int stall_cycles;

	ooo_core dut0 (
		.clock(clock),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.stall(stall),
		.commit_valid(commit_valid),
		.commit_inst(commit_inst),
		.commit_wr_en(commit_wr_en),
		.commit_wr_idx(commit_wr_idx),
		.commit_wr_data(commit_wr_data)
	);

	always #50 clock = ~clock;

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////
	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return bits;
	endfunction

	function automatic ooo_isa_pkg::inst_t encode_r(input logic [6:0] funct7,
			input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic ooo_isa_pkg::inst_t encode_addi(input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	// registers limited to x0..x7 so renames collide often
	function automatic ooo_isa_pkg::inst_t random_word();
		logic [2:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		kind = 3'(random_bits(3));
		rd   = {2'b00, 3'(random_bits(3))};
		rs1  = {2'b00, 3'(random_bits(3))};
		rs2  = {2'b00, 3'(random_bits(3))};
		imm  = 12'(random_bits(12));
		case (kind)
			3'd0:    return encode_r(7'h00, 3'b000, rd, rs1, rs2);
			3'd1:    return encode_r(7'h20, 3'b000, rd, rs1, rs2);
			3'd2:    return encode_r(7'h00, 3'b111, rd, rs1, rs2);
			3'd3:    return encode_r(7'h00, 3'b110, rd, rs1, rs2);
			3'd4:    return encode_r(7'h00, 3'b100, rd, rs1, rs2);
			3'd5:    return encode_r(7'h00, 3'b010, rd, rs1, rs2);
			default: return encode_addi(rd, rs1, imm);
		endcase
	endfunction

	// called 1 ns after a rising edge, holds the word until accepted
	task automatic send_word(input ooo_isa_pkg::inst_t word, input string name);
		logic accepted;
		accepted   = 1'b0;
		inst_valid = 1'b1;
		inst       = word;
		while (!accepted) begin
			@(negedge clock);
			if (!stall) begin
				accepted = 1'b1;
				word_q.push_back(word);
				name_q.push_back(name);
				accepted_count++;
			end
			@(posedge clock);
			#1;
		end
	endtask

	// drop valid and wait until every accepted word retired, or give up
	task automatic wait_for_drain();
		int waited;
		inst_valid = 1'b0;
		waited     = 0;
		while (word_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		repeat (2) @(posedge clock);
		#1;
	endtask

	task automatic report_mismatch(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		value_errors++;
		$display("FAIL %s %s expected %h actual %h", name, field, expected, actual);
	endtask

	task automatic print_counts();
		$display("commits %0d, checks %0d, value errors %0d, other errors %0d",
			commit_count, checks, value_errors, other_errors);
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////
	// strictly in order, one call per retired word
	function automatic expect_t reference_execute(input ooo_isa_pkg::inst_t word);
		logic [6:0]          opcode;
		logic [2:0]          funct3;
		logic [6:0]          funct7;
		logic [4:0]          rd;
		ooo_core_pkg::data_t a;
		ooo_core_pkg::data_t b;
		ooo_core_pkg::data_t result;
		logic                supported;
		expect_t             exp;
		opcode    = word[6:0];
		rd        = word[11:7];
		funct3    = word[14:12];
		funct7    = word[31:25];
		a         = ref_regs[word[19:15]];
		b         = ref_regs[word[24:20]];
		result    = '0;
		supported = 1'b1;
		if (opcode == 7'b0110011 && funct7 == 7'h00) begin
			case (funct3)
				3'b000:  result = a + b;
				3'b010:  result = {31'b0, $signed(a) < $signed(b)};
				3'b100:  result = a ^ b;
				3'b110:  result = a | b;
				3'b111:  result = a & b;
				default: supported = 1'b0;
			endcase
		end else if (opcode == 7'b0110011 && funct7 == 7'h20 && funct3 == 3'b000) begin
			result = a - b;
		end else if (opcode == 7'b0010011 && funct3 == 3'b000) begin
			result = a + {{20{word[31]}}, word[31:20]};
		end else begin
			supported = 1'b0;
		end
		// anything unsupported retires as a nop aimed at x0
		exp.wr_en   = supported && rd != 5'd0;
		exp.wr_idx  = supported ? rd : 5'd0;
		exp.wr_data = result;
		if (exp.wr_en) begin
			ref_regs[rd] = result;
		end
		return exp;
	endfunction

	//////////////////////////////
	// commit checker
	//////////////////////////////
	always @(negedge clock) begin : compare
		ooo_isa_pkg::inst_t word;
		string              name;
		expect_t            exp;
		if (!reset && commit_valid) begin
			commit_count++;
			assert (word_q.size() > 0) else begin
				other_errors++;
				$display("commit of %h with no accepted word outstanding", commit_inst);
			end
			if (word_q.size() > 0) begin
				word = word_q.pop_front();
				name = name_q.pop_front();
				exp  = reference_execute(word);
				checks++;
				assert (commit_inst === word)
					else report_mismatch(name, "commit_inst", word, commit_inst);
				assert (commit_wr_en === exp.wr_en)
					else report_mismatch(name, "wr_en", 32'(exp.wr_en), 32'(commit_wr_en));
				assert (commit_wr_idx === exp.wr_idx)
					else report_mismatch(name, "wr_idx", 32'(exp.wr_idx), 32'(commit_wr_idx));
				// data only means something when a register is written
				if (exp.wr_en) begin
					assert (commit_wr_data === exp.wr_data)
						else report_mismatch(name, "wr_data", exp.wr_data, commit_wr_data);
				end
			end
		end
	end

	always @(negedge clock) begin
		if (!reset && stall) begin
			stall_cycles++;
		end
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d accepted words never committed",
			cycles, word_q.size());
		print_counts();
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		clock          = 1'b0;
		reset          = 1'b1;
		inst_valid     = 1'b0;
		inst           = '0;
		lfsr_state     = 32'd30;
		accepted_count = 0;
		commit_count   = 0;
		checks         = 0;
		value_errors   = 0;
		other_errors   = 0;
		stall_cycles   = 0;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		// quiet outputs until the first word
		repeat (3) begin
			@(negedge clock);
			assert (!commit_valid && !stall) else begin
				other_errors++;
				$display("commit_valid or stall high after reset with no word driven");
			end
		end
		@(posedge clock);
		#1;

		// independent addi into x1..x8
		for (int r = 1; r <= 8; r++) begin
			send_word(encode_addi(5'(r), 5'd0, 12'(random_bits(12))), "addi_independent");
		end
		wait_for_drain();

		for (int n = 0; n < 150; n++) begin
			send_word(random_word(), "dependent_chain");
		end
		wait_for_drain();

		// serial add chain keeps the rs full
		stall_cycles = 0;
		send_word(encode_addi(5'd9, 5'd0, 12'd1), "back_pressure");
		send_word(encode_addi(5'd1, 5'd0, 12'd3), "back_pressure");
		for (int n = 0; n < 30; n++) begin
			send_word(encode_r(7'h00, 3'b000, 5'd9, 5'd9, 5'd1), "back_pressure");
		end
		wait_for_drain();
		assert (stall_cycles > 0) else begin
			other_errors++;
			$display("stall never rose during the dependent add burst");
		end
		assert (commit_count == accepted_count) else begin
			other_errors++;
			$display("lost instruction, %0d accepted but %0d committed",
				accepted_count, commit_count);
		end

		// x0 writes, then lw, sll, slli and an all-zero word
		send_word(encode_addi(5'd0, 5'd0, 12'h7ff), "x0_unsupported");
		send_word(encode_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), "x0_unsupported");
		send_word(32'h0000_2083, "x0_unsupported");
		send_word(encode_r(7'h00, 3'b001, 5'd3, 5'd1, 5'd2), "x0_unsupported");
		send_word({12'h001, 5'd1, 3'b001, 5'd4, 7'b0010011}, "x0_unsupported");
		send_word(32'h0000_0000, "x0_unsupported");
		send_word(encode_r(7'h00, 3'b000, 5'd5, 5'd0, 5'd0), "x0_unsupported");
		send_word(encode_r(7'h00, 3'b000, 5'd7, 5'd0, 5'd1), "x0_unsupported");
		wait_for_drain();

		// x13 is ready at once and overtakes the x11/x12 chain
		send_word(encode_addi(5'd10, 5'd0, 12'd100), "commit_order");
		send_word(encode_r(7'h00, 3'b000, 5'd11, 5'd10, 5'd10), "commit_order");
		send_word(encode_r(7'h00, 3'b000, 5'd12, 5'd11, 5'd11), "commit_order");
		send_word(encode_addi(5'd13, 5'd0, 12'hffb), "commit_order");
		send_word(encode_r(7'h20, 3'b000, 5'd14, 5'd12, 5'd13), "commit_order");
		send_word(encode_r(7'h00, 3'b010, 5'd15, 5'd13, 5'd10), "commit_order");
		wait_for_drain();

		assert (commit_count == accepted_count) else begin
			other_errors++;
			$display("lost instruction, %0d accepted but %0d committed",
				accepted_count, commit_count);
		end
		print_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
design/ooo_isa_pkg.sv
design/ooo_core_pkg.sv
design/issue_stage.sv
design/map_table.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/alu_stage.sv
design/ooo_core.sv
testbench/ooo_core_tb.sv

/* Makefile */
# Verilator build and run for the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
